//--- Bender.yml
package:
  name: soc_clk_rst_gen

sources:
  - src/clk_cfg_pkg.sv
  - src/clk_ctrl_pkg.sv
  - src/cfg_regfile.sv
  - src/settle_timer.sv
  - src/lock_fsm.sv
  - src/clk_divider.sv
  - src/reset_sync.sv
  - src/clk_channel.sv
  - src/soc_clk_rst_gen.sv
  - target: simulation
    files:
      - sim/tb_soc_clk_rst_gen.sv

//--- compile.f
src/clk_cfg_pkg.sv
src/clk_ctrl_pkg.sv
src/cfg_regfile.sv
src/settle_timer.sv
src/lock_fsm.sv
src/clk_divider.sv
src/reset_sync.sv
src/clk_channel.sv
src/soc_clk_rst_gen.sv
sim/tb_soc_clk_rst_gen.sv

//--- sim/tb_soc_clk_rst_gen.sv
`default_nettype none

module tb_soc_clk_rst_gen;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RST_EDGES  = clk_ctrl_pkg::RST_EDGES_DEFAULT;
  localparam int          WAIT_LIMIT = 400;  // cycles any single wait may take
  localparam int          ACK_LIMIT  = 8;
  localparam int          N_ACCESS   = 80;

  logic        clk;
  logic        reset_i;
  logic        req [3];
  logic        wrn [3];
  logic [4:0]  add [3];
  logic [31:0] data [3];

  logic        soc_ack;
  logic        per_ack;
  logic        cluster_ack;
  logic [31:0] soc_rdata;
  logic [31:0] per_rdata;
  logic [31:0] cluster_rdata;
  logic        soc_lock;
  logic        per_lock;
  logic        cluster_lock;
  logic        clk_soc;
  logic        clk_per;
  logic        clk_cluster;
  logic        rst_soc;
  logic        rst_cluster;

  // outputs gathered per channel, index 0 soc, 1 per, 2 cluster
  logic        ack [3];
  logic [31:0] rdata [3];
  logic        lock [3];
  logic        dclk [3];
  logic        rst [3];

  // register model of each port
  logic        m_en [3];
  logic [7:0]  m_div [3];
  logic [15:0] m_settle [3];
  int          m_lock_edge [3];  // cycle at which lock is expected to be seen high

  // what the sampling loop has observed so far
  int          cyc;
  logic        lock_prev [3];
  logic        clk_prev [3];
  int          lock_rise [3];
  int          lock_fall [3];
  int          clk_rise [3];
  int          clk_period [3];
  int          n_rise [3];
  int          rel_phase [3];
  int          rel_base [3];

  int          errors;
  int          tests_run;
  int          tests_failed;
  string       pfx [3] = '{"soc", "per", "cluster"};

  soc_clk_rst_gen #(
    .RST_EDGES(RST_EDGES)
  ) dut (
    .clk             (clk),
    .reset_i         (reset_i),
    .soc_req_i       (req[0]),
    .soc_wrn_i       (wrn[0]),
    .soc_add_i       (add[0]),
    .soc_data_i      (data[0]),
    .soc_ack_o       (soc_ack),
    .soc_r_data_o    (soc_rdata),
    .soc_lock_o      (soc_lock),
    .per_req_i       (req[1]),
    .per_wrn_i       (wrn[1]),
    .per_add_i       (add[1]),
    .per_data_i      (data[1]),
    .per_ack_o       (per_ack),
    .per_r_data_o    (per_rdata),
    .per_lock_o      (per_lock),
    .cluster_req_i   (req[2]),
    .cluster_wrn_i   (wrn[2]),
    .cluster_add_i   (add[2]),
    .cluster_data_i  (data[2]),
    .cluster_ack_o   (cluster_ack),
    .cluster_r_data_o(cluster_rdata),
    .cluster_lock_o  (cluster_lock),
    .clk_soc_o       (clk_soc),
    .clk_per_o       (clk_per),
    .clk_cluster_o   (clk_cluster),
    .rst_soc_o       (rst_soc),
    .rst_cluster_o   (rst_cluster)
  );

  always_comb begin
    ack[0]   = soc_ack;
    ack[1]   = per_ack;
    ack[2]   = cluster_ack;
    rdata[0] = soc_rdata;
    rdata[1] = per_rdata;
    rdata[2] = cluster_rdata;
    lock[0]  = soc_lock;
    lock[1]  = per_lock;
    lock[2]  = cluster_lock;
    dclk[0]  = clk_soc;
    dclk[1]  = clk_per;
    dclk[2]  = clk_cluster;
    rst[0]   = rst_soc;
    rst[1]   = 1'b1;  // the peripheral domain has no reset output
    rst[2]   = rst_cluster;
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic fail_msg(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // advance to the next falling edge and log lock and clock events of all channels
  task automatic step();
    @(negedge clk);
    cyc++;
    for (int ch = 0; ch < 3; ch++) begin
      if (lock[ch] && !lock_prev[ch]) begin
        lock_rise[ch] = cyc;
      end
      if (!lock[ch] && lock_prev[ch]) begin
        lock_fall[ch] = cyc;
      end
      if (dclk[ch] && !clk_prev[ch]) begin
        clk_period[ch] = cyc - clk_rise[ch];
        clk_rise[ch]   = cyc;
        n_rise[ch]++;
      end
      if (dclk[ch] && !lock[ch] && !lock_prev[ch]) begin
        fail_msg($sformatf("%s domain clock is high while the channel is unlocked", pfx[ch]));
      end
      lock_prev[ch] = lock[ch];
      clk_prev[ch]  = dclk[ch];
    end
  endtask

  // one req strobe, returns the read data and the cycle in which ack was seen
  task automatic access(input int ch, input logic wr, input logic [4:0] a,
                        input logic [31:0] d, output logic [31:0] rd, output int ack_cyc);
    int n;
    n        = 0;
    req[ch]  = 1'b1;
    wrn[ch]  = wr;
    add[ch]  = a;
    data[ch] = d;
    do begin
      step();
      n++;
      req[ch] = 1'b0;
    end while (!ack[ch] && n < ACK_LIMIT);
    rd      = rdata[ch];
    ack_cyc = cyc;
    if (!ack[ch]) begin
      fail_msg($sformatf("no ack on the %s port within %0d cycles", pfx[ch], ACK_LIMIT));
    end else if (n != 1) begin
      value_error($sformatf("%s_ack_o delay", pfx[ch]), n, 1);
    end
    step();
    if (ack[ch] !== 1'b0) begin
      value_error($sformatf("%s_ack_o width", pfx[ch]), ack[ch], 0);
    end
  endtask

  task automatic write_reg(input int ch, input logic [4:0] a, input logic [31:0] d,
                           output int ack_cyc);
    logic [31:0] rd;
    access(ch, 1'b1, a, d, rd, ack_cyc);
    case (a)
      clk_cfg_pkg::ADDR_CTRL: begin
        m_en[ch] = d[0];
        if (d[0]) begin
          m_lock_edge[ch] = ack_cyc + int'(m_settle[ch]) + 2;
        end
      end
      clk_cfg_pkg::ADDR_DIV: begin
        m_div[ch] = d[7:0];
        if (m_en[ch]) begin
          m_lock_edge[ch] = ack_cyc + int'(m_settle[ch]) + 2;
        end
      end
      clk_cfg_pkg::ADDR_SETTLE: m_settle[ch] = d[15:0];
      default: ;
    endcase
  endtask

  // status shows the state as it was just before the req was sampled
  function automatic logic [31:0] expected_read(input int ch, input logic [4:0] a, input int n);
    logic [31:0] v;
    v = '0;
    case (a)
      clk_cfg_pkg::ADDR_CTRL:   v[0] = m_en[ch];
      clk_cfg_pkg::ADDR_DIV:    v[7:0] = m_div[ch];
      clk_cfg_pkg::ADDR_SETTLE: v[15:0] = m_settle[ch];
      clk_cfg_pkg::ADDR_STATUS: begin
        if (!m_en[ch]) begin
          v[2:0] = {clk_ctrl_pkg::ST_OFF, 1'b0};
        end else if (n - 1 >= m_lock_edge[ch]) begin
          v[2:0] = {clk_ctrl_pkg::ST_LOCKED, 1'b1};
        end else begin
          v[2:0] = {clk_ctrl_pkg::ST_SETTLE, 1'b0};
        end
      end
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic read_check(input int ch, input logic [4:0] a);
    logic [31:0] rd;
    logic [31:0] exp;
    int          n;
    access(ch, 1'b0, a, $urandom(), rd, n);
    exp = expected_read(ch, a, n);
    if (rd !== exp) begin
      value_error($sformatf("%s_r_data_o at address %0d", pfx[ch], a), rd, exp);
    end
  endtask

  task automatic wait_lock(input int ch);
    int t;
    t = 0;
    while (!lock[ch] && t < WAIT_LIMIT) begin
      step();
      t++;
    end
    if (!lock[ch]) begin
      fail_msg($sformatf("%s channel did not lock within %0d cycles", pfx[ch], WAIT_LIMIT));
    end else if (lock_rise[ch] != m_lock_edge[ch]) begin
      value_error($sformatf("%s_lock_o rise cycle", pfx[ch]), lock_rise[ch], m_lock_edge[ch]);
    end
  endtask

  task automatic check_period(input int ch);
    int          start;
    int          seen;
    int          t;
    logic [31:0] exp;
    start = n_rise[ch];
    seen  = 0;
    t     = 0;
    exp   = 2 * (m_div[ch] + 1);
    while (seen < 5 && t < WAIT_LIMIT) begin
      step();
      t++;
      if (n_rise[ch] - start > seen) begin
        seen = n_rise[ch] - start;
        if (seen > 1 && clk_period[ch] != exp) begin  // first edge has no reference
          value_error($sformatf("%s domain clock period", pfx[ch]), clk_period[ch], exp);
        end
      end
    end
    if (seen < 5) begin
      fail_msg($sformatf("%s domain clock stopped toggling", pfx[ch]));
    end
  endtask

  // each selected reset must stay high through lock and RST_EDGES clock edges, then drop
  task automatic release_check(input logic [2:0] sel);
    int t;
    t = 0;
    for (int ch = 0; ch < 3; ch++) begin
      rel_phase[ch] = sel[ch] ? 0 : 3;
    end
    while ((rel_phase[0] != 3 || rel_phase[1] != 3 || rel_phase[2] != 3) && t < WAIT_LIMIT) begin
      step();
      t++;
      for (int ch = 0; ch < 3; ch++) begin
        if (rel_phase[ch] == 2) begin
          if (rst[ch] !== 1'b0) begin
            value_error($sformatf("rst_%s_o", pfx[ch]), rst[ch], 0);
          end
          rel_phase[ch] = 3;
        end else if (rel_phase[ch] < 2) begin
          if (rst[ch] !== 1'b1) begin
            value_error($sformatf("rst_%s_o", pfx[ch]), rst[ch], 1);
          end
          if (rel_phase[ch] == 0 && lock[ch]) begin
            rel_phase[ch] = 1;
            rel_base[ch]  = n_rise[ch];
          end else if (rel_phase[ch] == 1 && n_rise[ch] - rel_base[ch] >= RST_EDGES) begin
            rel_phase[ch] = 2;
          end
        end
      end
    end
    if (rel_phase[0] != 3 || rel_phase[1] != 3 || rel_phase[2] != 3) begin
      fail_msg("domain reset was not released in time");
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    int unsigned seed;
    int          e0;
    int          n;
    int          t;
    logic [4:0]  a;
    logic [31:0] d;
    seed         = 32'hdaa1_185e;
    void'($urandom(seed));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cyc          = 0;
    reset_i      = 1'b1;
    for (int ch = 0; ch < 3; ch++) begin
      req[ch]        = 1'b0;
      wrn[ch]        = 1'b0;
      add[ch]        = '0;
      data[ch]       = '0;
      m_en[ch]       = 1'b1;
      lock_prev[ch]  = 1'b0;
      clk_prev[ch]   = 1'b0;
      lock_rise[ch]  = 0;
      lock_fall[ch]  = 0;
      clk_rise[ch]   = 0;
      clk_period[ch] = 0;
      n_rise[ch]     = 0;
    end
    m_div[0]    = clk_cfg_pkg::SOC_DIV_RST;
    m_div[1]    = clk_cfg_pkg::PER_DIV_RST;
    m_div[2]    = clk_cfg_pkg::CLUSTER_DIV_RST;
    m_settle[0] = clk_cfg_pkg::SOC_SETTLE_RST;
    m_settle[1] = clk_cfg_pkg::PER_SETTLE_RST;
    m_settle[2] = clk_cfg_pkg::CLUSTER_SETTLE_RST;
    step();
    step();
    reset_i = 1'b0;

    e0 = errors;
    step();
    for (int ch = 0; ch < 3; ch++) begin
      if (ack[ch] !== 1'b0 || rdata[ch] !== '0 || lock[ch] !== 1'b0 || dclk[ch] !== 1'b0) begin
        fail_msg($sformatf("%s channel outputs are not idle after reset", pfx[ch]));
      end
    end
    if (rst_soc !== 1'b1 || rst_cluster !== 1'b1) begin
      fail_msg("domain resets are not asserted after reset");
    end
    release_check(3'b101);
    t = 0;
    while (!lock[1] && t < WAIT_LIMIT) begin
      step();
      t++;
    end
    if (!lock[1]) begin
      fail_msg("per channel never locked after reset");
    end
    for (int ch = 0; ch < 3; ch++) begin
      m_lock_edge[ch] = lock_rise[ch];
    end
    end_test("reset release", e0);

    e0 = errors;
    for (int i = 0; i < N_ACCESS; i++) begin
      a = ($urandom_range(0, 3) == 0) ? 5'($urandom_range(4, 31)) : 5'($urandom_range(0, 3));
      d = $urandom();
      if (a == clk_cfg_pkg::ADDR_DIV) begin
        d[7:4] = 4'h0;  // divide stays at 15 or less
      end
      if (a == clk_cfg_pkg::ADDR_SETTLE) begin
        d[15:6] = '0;
      end
      if (a == clk_cfg_pkg::ADDR_CTRL) begin
        d[0] = 1'b1;
      end
      if ($urandom_range(0, 1) == 1) begin
        write_reg($urandom_range(0, 2), a, d, n);
      end else begin
        read_check($urandom_range(0, 2), a);
      end
    end
    end_test("register access", e0);

    e0 = errors;
    for (int ch = 0; ch < 3; ch++) begin
      wait_lock(ch);
      write_reg(ch, clk_cfg_pkg::ADDR_SETTLE, $urandom_range(0, 40), n);
      write_reg(ch, clk_cfg_pkg::ADDR_DIV, $urandom_range(0, 15), n);
      if (lock_fall[ch] != n + 1) begin
        value_error($sformatf("%s_lock_o fall cycle", pfx[ch]), lock_fall[ch], n + 1);
      end
      read_check(ch, clk_cfg_pkg::ADDR_STATUS);
      wait_lock(ch);
      read_check(ch, clk_cfg_pkg::ADDR_STATUS);
    end
    end_test("lock timing", e0);

    e0 = errors;
    for (int ch = 0; ch < 3; ch++) begin
      check_period(ch);
    end
    end_test("clock period", e0);

    e0 = errors;
    for (int ch = 0; ch < 3; ch++) begin
      write_reg(ch, clk_cfg_pkg::ADDR_CTRL, 32'h0, n);
      if (lock_fall[ch] != n + 1) begin
        value_error($sformatf("%s_lock_o fall cycle", pfx[ch]), lock_fall[ch], n + 1);
      end
      for (int k = 0; k < 2 * (m_div[ch] + 1) + 4; k++) begin
        step();
        if (dclk[ch] !== 1'b0) begin
          value_error($sformatf("%s domain clock", pfx[ch]), dclk[ch], 0);
        end
        if (ch != 1 && rst[ch] !== 1'b1) begin
          value_error($sformatf("rst_%s_o", pfx[ch]), rst[ch], 1);
        end
      end
      read_check(ch, clk_cfg_pkg::ADDR_STATUS);
      write_reg(ch, clk_cfg_pkg::ADDR_CTRL, 32'h1, n);
      if (ch != 1) begin
        release_check(3'b001 << ch);
      end
      wait_lock(ch);
    end
    end_test("disable", e0);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/cfg_regfile.sv
`default_nettype none

module cfg_regfile #(
  parameter logic [clk_cfg_pkg::DIV_W-1:0]    DIV_RESET    = clk_cfg_pkg::SOC_DIV_RST,
  parameter logic [clk_cfg_pkg::SETTLE_W-1:0] SETTLE_RESET = clk_cfg_pkg::SOC_SETTLE_RST
) (
  input  wire logic                              clk,
  input  wire logic                              reset_i,
  input  wire logic                              req_i,
  input  wire logic                              wrn_i,
  input  wire logic [clk_cfg_pkg::ADDR_W-1:0]    add_i,
  input  wire logic [clk_cfg_pkg::DATA_W-1:0]    data_i,
  input  wire logic                              lock_i,
  input  wire clk_ctrl_pkg::lock_state_e         state_i,
  output logic                                   ack_o,
  output logic      [clk_cfg_pkg::DATA_W-1:0]    r_data_o,
  output logic                                   enable_o,
  output logic      [clk_cfg_pkg::DIV_W-1:0]     div_o,
  output logic      [clk_cfg_pkg::SETTLE_W-1:0]  settle_o,
  output logic                                   relock_o
);

  logic                             enable_q;
  logic [clk_cfg_pkg::DIV_W-1:0]    div_q;
  logic [clk_cfg_pkg::SETTLE_W-1:0] settle_q;
  logic [clk_cfg_pkg::DATA_W-1:0]   rdata_d;
  logic [clk_cfg_pkg::DATA_W-1:0]   rdata_q;
  logic                             ack_q;
  logic                             relock_q;
  logic                             wr_en;

  assign wr_en = req_i && wrn_i;  // wrn high means write on this port

  // fields are written on the req cycle so the ack cycle already sees them
  always_ff @(posedge clk) begin
    if (reset_i) begin
      enable_q <= 1'b1;
      div_q    <= DIV_RESET;
      settle_q <= SETTLE_RESET;
    end else if (wr_en) begin
      case (clk_cfg_pkg::cfg_addr_e'(add_i))
        clk_cfg_pkg::ADDR_CTRL:   enable_q <= data_i[0];
        clk_cfg_pkg::ADDR_DIV:    div_q    <= data_i[clk_cfg_pkg::DIV_W-1:0];
        clk_cfg_pkg::ADDR_SETTLE: settle_q <= data_i[clk_cfg_pkg::SETTLE_W-1:0];
        default: ;  // status is read only
      endcase
    end
  end

  always_comb begin
    rdata_d = '0;
    case (clk_cfg_pkg::cfg_addr_e'(add_i))
      clk_cfg_pkg::ADDR_CTRL:   rdata_d[0] = enable_q;
      clk_cfg_pkg::ADDR_DIV:    rdata_d[clk_cfg_pkg::DIV_W-1:0] = div_q;
      clk_cfg_pkg::ADDR_STATUS: rdata_d[clk_ctrl_pkg::STATE_W:0] = {state_i, lock_i};
      clk_cfg_pkg::ADDR_SETTLE: rdata_d[clk_cfg_pkg::SETTLE_W-1:0] = settle_q;
      default:                  rdata_d = '0;
    endcase
  end

  // a new divide or a ctrl write both restart the settle sequence
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q    <= 1'b0;
      relock_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      ack_q    <= req_i;
      relock_q <= wr_en && (add_i == clk_cfg_pkg::ADDR_CTRL || add_i == clk_cfg_pkg::ADDR_DIV);
      if (req_i && !wrn_i) begin
        rdata_q <= rdata_d;  // held until the next read
      end
    end
  end

  assign ack_o    = ack_q;
  assign r_data_o = rdata_q;
  assign relock_o = relock_q;
  assign enable_o = enable_q;
  assign div_o    = div_q;
  assign settle_o = settle_q;

endmodule

`default_nettype wire

//--- src/clk_cfg_pkg.sv
`default_nettype none

package clk_cfg_pkg;

  // widths of the config port and its fields
  localparam int unsigned ADDR_W   = 5;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned DIV_W    = 8;
  localparam int unsigned SETTLE_W = 16;

  // register map, any address not listed reads zero and drops writes
  typedef enum logic [ADDR_W-1:0] {
    ADDR_CTRL   = 5'd0,  // bit 0 enables the channel
    ADDR_DIV    = 5'd1,  // half period minus one, in clk cycles
    ADDR_STATUS = 5'd2,  // read only, {state, lock}
    ADDR_SETTLE = 5'd3   // cycles the channel waits before it reports lock
  } cfg_addr_e;

  // divide values each domain comes out of reset with
  localparam logic [DIV_W-1:0] SOC_DIV_RST     = 8'd1;
  localparam logic [DIV_W-1:0] PER_DIV_RST     = 8'd3;
  localparam logic [DIV_W-1:0] CLUSTER_DIV_RST = 8'd0;

  // settle counts after reset
  localparam logic [SETTLE_W-1:0] SOC_SETTLE_RST     = 16'd20;
  localparam logic [SETTLE_W-1:0] PER_SETTLE_RST     = 16'd12;
  localparam logic [SETTLE_W-1:0] CLUSTER_SETTLE_RST = 16'd30;

endpackage

`default_nettype wire

//--- src/clk_channel.sv
`default_nettype none

module clk_channel #(
  parameter logic [clk_cfg_pkg::DIV_W-1:0]    DIV_RESET    = clk_cfg_pkg::SOC_DIV_RST,
  parameter logic [clk_cfg_pkg::SETTLE_W-1:0] SETTLE_RESET = clk_cfg_pkg::SOC_SETTLE_RST
) (
  input  wire logic                           clk,
  input  wire logic                           reset_i,
  input  wire logic                           req_i,
  input  wire logic                           wrn_i,
  input  wire logic [clk_cfg_pkg::ADDR_W-1:0] add_i,
  input  wire logic [clk_cfg_pkg::DATA_W-1:0] data_i,
  output logic                                ack_o,
  output logic      [clk_cfg_pkg::DATA_W-1:0] r_data_o,
  output logic                                lock_o,
  output logic                                clk_o,
  output logic                                rise_o
);

  logic                             enable;
  logic [clk_cfg_pkg::DIV_W-1:0]    div;
  logic [clk_cfg_pkg::SETTLE_W-1:0] settle;
  logic                             relock;
  logic                             load;
  logic                             expired;
  logic                             lock;
  clk_ctrl_pkg::lock_state_e        state;

  cfg_regfile #(
    .DIV_RESET   (DIV_RESET),
    .SETTLE_RESET(SETTLE_RESET)
  ) i_regfile (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req_i),
    .wrn_i   (wrn_i),
    .add_i   (add_i),
    .data_i  (data_i),
    .lock_i  (lock),
    .state_i (state),
    .ack_o   (ack_o),
    .r_data_o(r_data_o),
    .enable_o(enable),
    .div_o   (div),
    .settle_o(settle),
    .relock_o(relock)
  );

  // stands in for the loop filter, just waits settle cycles
  settle_timer i_timer (
    .clk      (clk),
    .reset_i  (reset_i),
    .load_i   (load),
    .count_i  (settle),
    .expired_o(expired)
  );

  lock_fsm i_lock_fsm (
    .clk      (clk),
    .reset_i  (reset_i),
    .enable_i (enable),
    .relock_i (relock),
    .expired_i(expired),
    .load_o   (load),
    .lock_o   (lock),
    .state_o  (state)
  );

  clk_divider i_divider (
    .clk    (clk),
    .reset_i(reset_i),
    .run_i  (lock),  // no clock until the channel reports lock
    .div_i  (div),
    .clk_o  (clk_o),
    .rise_o (rise_o)
  );

  assign lock_o = lock;

endmodule

`default_nettype wire

//--- src/clk_ctrl_pkg.sv
`default_nettype none

package clk_ctrl_pkg;

  // width of the lock state as it shows up in the status register
  localparam int unsigned STATE_W = 2;

  // lock state of one clock channel
  typedef enum logic [STATE_W-1:0] {
    ST_OFF    = 2'd0,  // channel disabled, clock held low
    ST_SETTLE = 2'd1,  // new setting applied, waiting for the timer
    ST_LOCKED = 2'd2   // divider running
  } lock_state_e;

  // domain clock rising edges seen after lock before a domain reset lets go
  localparam int unsigned RST_EDGES_DEFAULT = 4;

endpackage

`default_nettype wire

//--- src/clk_divider.sv
`default_nettype none

module clk_divider (
  input  wire logic                          clk,
  input  wire logic                          reset_i,
  input  wire logic                          run_i,
  input  wire logic [clk_cfg_pkg::DIV_W-1:0] div_i,
  output logic                               clk_o,
  output logic                               rise_o
);

  logic [clk_cfg_pkg::DIV_W-1:0] half_q;
  logic                          clk_q;
  logic                          rise_q;
  logic                          half_done;

  // >= so a smaller divide written mid half period cannot overrun the counter
  assign half_done = (half_q >= div_i);

  always_ff @(posedge clk) begin
    if (reset_i || !run_i) begin
      half_q <= '0;
      clk_q  <= 1'b0;  // output parks low while unlocked
      rise_q <= 1'b0;
    end else begin
      rise_q <= half_done && !clk_q;  // lines up with clk_q going high
      if (half_done) begin
        half_q <= '0;
        clk_q  <= ~clk_q;
      end else begin
        half_q <= half_q + 1'b1;
      end
    end
  end

  assign clk_o  = clk_q;
  assign rise_o = rise_q;

endmodule

`default_nettype wire

//--- src/lock_fsm.sv
`default_nettype none

module lock_fsm (
  input  wire logic                clk,
  input  wire logic                reset_i,
  input  wire logic                enable_i,
  input  wire logic                relock_i,
  input  wire logic                expired_i,
  output logic                     load_o,
  output logic                     lock_o,
  output clk_ctrl_pkg::lock_state_e state_o
);

  clk_ctrl_pkg::lock_state_e state_q;
  clk_ctrl_pkg::lock_state_e state_d;

  // disable wins over everything, relock restarts the settle from any on state
  always_comb begin
    state_d = state_q;
    load_o  = 1'b0;
    case (state_q)
      clk_ctrl_pkg::ST_OFF: begin
        if (enable_i) begin
          state_d = clk_ctrl_pkg::ST_SETTLE;
          load_o  = 1'b1;
        end
      end
      clk_ctrl_pkg::ST_SETTLE: begin
        if (!enable_i) begin
          state_d = clk_ctrl_pkg::ST_OFF;
        end else if (relock_i) begin
          load_o = 1'b1;  // timer starts over with the current settle value
        end else if (expired_i) begin
          state_d = clk_ctrl_pkg::ST_LOCKED;
        end
      end
      clk_ctrl_pkg::ST_LOCKED: begin
        if (!enable_i) begin
          state_d = clk_ctrl_pkg::ST_OFF;
        end else if (relock_i) begin
          state_d = clk_ctrl_pkg::ST_SETTLE;
          load_o  = 1'b1;
        end
      end
      default: state_d = clk_ctrl_pkg::ST_OFF;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= clk_ctrl_pkg::ST_SETTLE;  // channels come up enabled
    end else begin
      state_q <= state_d;
    end
  end

  assign lock_o  = (state_q == clk_ctrl_pkg::ST_LOCKED);
  assign state_o = state_q;

endmodule

`default_nettype wire

//--- src/reset_sync.sv
`default_nettype none

module reset_sync #(
  parameter int unsigned RST_EDGES = clk_ctrl_pkg::RST_EDGES_DEFAULT
) (
  input  wire logic clk,
  input  wire logic reset_i,
  input  wire logic lock_i,
  input  wire logic rise_i,
  output logic      rst_o
);

  localparam int unsigned CNT_W = $clog2(RST_EDGES + 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (reset_i || !lock_i) begin
      cnt_q <= '0;  // losing lock starts the count over
    end else if (rise_i && cnt_q != CNT_W'(RST_EDGES)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // straight from the counter so lock loss shows up on the very next cycle
  assign rst_o = (cnt_q != CNT_W'(RST_EDGES));

endmodule

`default_nettype wire

//--- src/settle_timer.sv
`default_nettype none

module settle_timer (
  input  wire logic                             clk,
  input  wire logic                             reset_i,
  input  wire logic                             load_i,
  input  wire logic [clk_cfg_pkg::SETTLE_W-1:0] count_i,
  output logic                                  expired_o
);

  logic [clk_cfg_pkg::SETTLE_W-1:0] cnt_q;

  // the channel leaves reset already settling, so reset loads the count as well
  always_ff @(posedge clk) begin
    if (reset_i || load_i) begin
      cnt_q <= count_i;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;  // stops at zero
    end
  end

  // level, stays up until the next load
  assign expired_o = (cnt_q == '0);

endmodule

`default_nettype wire

//--- src/soc_clk_rst_gen.sv
`default_nettype none

module soc_clk_rst_gen #(
  parameter int unsigned RST_EDGES = clk_ctrl_pkg::RST_EDGES_DEFAULT
) (
  input  wire logic                           clk,
  input  wire logic                           reset_i,

  input  wire logic                           soc_req_i,
  input  wire logic                           soc_wrn_i,
  input  wire logic [clk_cfg_pkg::ADDR_W-1:0] soc_add_i,
  input  wire logic [clk_cfg_pkg::DATA_W-1:0] soc_data_i,
  output logic                                soc_ack_o,
  output logic      [clk_cfg_pkg::DATA_W-1:0] soc_r_data_o,
  output logic                                soc_lock_o,

  input  wire logic                           per_req_i,
  input  wire logic                           per_wrn_i,
  input  wire logic [clk_cfg_pkg::ADDR_W-1:0] per_add_i,
  input  wire logic [clk_cfg_pkg::DATA_W-1:0] per_data_i,
  output logic                                per_ack_o,
  output logic      [clk_cfg_pkg::DATA_W-1:0] per_r_data_o,
  output logic                                per_lock_o,

  input  wire logic                           cluster_req_i,
  input  wire logic                           cluster_wrn_i,
  input  wire logic [clk_cfg_pkg::ADDR_W-1:0] cluster_add_i,
  input  wire logic [clk_cfg_pkg::DATA_W-1:0] cluster_data_i,
  output logic                                cluster_ack_o,
  output logic      [clk_cfg_pkg::DATA_W-1:0] cluster_r_data_o,
  output logic                                cluster_lock_o,

  output logic                                clk_soc_o,
  output logic                                clk_per_o,
  output logic                                clk_cluster_o,
  output logic                                rst_soc_o,
  output logic                                rst_cluster_o
);

  logic soc_rise;
  logic cluster_rise;

  clk_channel #(
    .DIV_RESET   (clk_cfg_pkg::SOC_DIV_RST),
    .SETTLE_RESET(clk_cfg_pkg::SOC_SETTLE_RST)
  ) i_soc_channel (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (soc_req_i),
    .wrn_i   (soc_wrn_i),
    .add_i   (soc_add_i),
    .data_i  (soc_data_i),
    .ack_o   (soc_ack_o),
    .r_data_o(soc_r_data_o),
    .lock_o  (soc_lock_o),
    .clk_o   (clk_soc_o),
    .rise_o  (soc_rise)
  );

  // peripheral domain has no reset of its own, it runs under the soc reset
  clk_channel #(
    .DIV_RESET   (clk_cfg_pkg::PER_DIV_RST),
    .SETTLE_RESET(clk_cfg_pkg::PER_SETTLE_RST)
  ) i_per_channel (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (per_req_i),
    .wrn_i   (per_wrn_i),
    .add_i   (per_add_i),
    .data_i  (per_data_i),
    .ack_o   (per_ack_o),
    .r_data_o(per_r_data_o),
    .lock_o  (per_lock_o),
    .clk_o   (clk_per_o),
    .rise_o  ()
  );

  clk_channel #(
    .DIV_RESET   (clk_cfg_pkg::CLUSTER_DIV_RST),
    .SETTLE_RESET(clk_cfg_pkg::CLUSTER_SETTLE_RST)
  ) i_cluster_channel (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (cluster_req_i),
    .wrn_i   (cluster_wrn_i),
    .add_i   (cluster_add_i),
    .data_i  (cluster_data_i),
    .ack_o   (cluster_ack_o),
    .r_data_o(cluster_r_data_o),
    .lock_o  (cluster_lock_o),
    .clk_o   (clk_cluster_o),
    .rise_o  (cluster_rise)
  );

  reset_sync #(
    .RST_EDGES(RST_EDGES)
  ) i_soc_rst (
    .clk    (clk),
    .reset_i(reset_i),
    .lock_i (soc_lock_o),
    .rise_i (soc_rise),
    .rst_o  (rst_soc_o)
  );

  reset_sync #(
    .RST_EDGES(RST_EDGES)
  ) i_cluster_rst (
    .clk    (clk),
    .reset_i(reset_i),
    .lock_i (cluster_lock_o),
    .rise_i (cluster_rise),
    .rst_o  (rst_cluster_o)
  );

endmodule

`default_nettype wire
